// ==== build.f ====
+incdir+.
cuIsaPkg.sv
cuStatePkg.sv
instrDecoder.sv
stateSequencer.sv
controlRom.sv
controlUnit.sv
tb_controlUnit.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module tb_controlUnit -o simv
	./obj_dir/simv | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module tb_controlUnit;

	// one entry per sequencer state, same order as the microcode numbering
	typedef enum int
	{
		idReset, idFetchAddr, idFetchReq, idFetchWait, idDecode, idDpImm, idDpImmFlags,
		idDpShift, idBranchTarget, idBranchUpdate, idBranchLink
	} wordId;

	localparam int numWords = 11;
	localparam int numRows = 8;
	localparam int clkPeriod = 8;

	logic                   CLK;
	logic                   rstN;
	logic [`CU_INSTR_W-1:0] ir;
	logic                   cond;
	logic                   moc;
	logic                   rfLd, irLd, marLd, frLd, rw, mov;
	logic                   mbSel, md, mh, miSel, shiftEn, sBit, clr;
	logic [1:0]             maSel, mfSel, mjSel;
	logic [`CU_CSEL_W-1:0]  mcSel;
	logic [`CU_SHIFT_W-1:0] shiftMode;
	logic [`CU_ALUOP_W-1:0] aluCode;
	logic [29:0]            ctrlWord;

	logic [29:0]            stateWord [numWords];
	string                  stateName [numWords];
	cuIsaPkg::instrClass    rowClass [numRows];
	logic                   rowLink [numRows];
	logic                   rowCond [numRows];
	int                     rowLen [numRows];
	wordId                  rowSeq [numRows][3];
	int                     rowCount;
	int                     checkCount;
	int                     errorCount;
	logic [15:0]            lfsr;

	controlUnit u_controlUnit (.*);

	assign ctrlWord = {rfLd, irLd, marLd, frLd, rw, mov, maSel, mbSel, mcSel, md, mfSel, mh,
		miSel, mjSel, shiftEn, shiftMode, sBit, aluCode, clr};

	initial
	begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	task automatic setWord(input wordId id, input string name, input logic [29:0] w);
		stateWord[id] = w;
		stateName[id] = name;
	endtask

	task automatic loadWords();
		// rfLd irLd marLd frLd rw mov, maSel, mbSel, mcSel, md, mfSel, mh, miSel,
		// mjSel, shiftEn, shiftMode, sBit, aluCode, clr
		setWord(idReset, "stReset", {6'b000000, 2'b00, 1'b0, 3'b000, 1'b0, 2'b00, 1'b0,
			1'b0, 2'b00, 1'b0, 3'b000, 1'b0, 5'b00000, 1'b1});
		setWord(idFetchAddr, "stFetchAddr", {6'b001000, 2'b10, 1'b0, 3'b000, 1'b1, 2'b00,
			1'b0, 1'b0, 2'b00, 1'b0, 3'b000, 1'b0, 5'b10000, 1'b0});
		setWord(idFetchReq, "stFetchReq", {6'b100011, 2'b10, 1'b0, 3'b011, 1'b1, 2'b00,
			1'b0, 1'b0, 2'b00, 1'b0, 3'b000, 1'b0, 5'b10001, 1'b0});
		setWord(idFetchWait, "stFetchWait", {6'b010011, 2'b00, 1'b0, 3'b000, 1'b0, 2'b00,
			1'b0, 1'b0, 2'b00, 1'b0, 3'b000, 1'b0, 5'b00000, 1'b0});
		setWord(idDecode, "stDecode", 30'h0);
		setWord(idDpImm, "stDpImm", {6'b100000, 2'b00, 1'b1, 3'b100, 1'b1, 2'b00,
			1'b0, 1'b0, 2'b00, 1'b1, 3'b001, 1'b0, 5'b10011, 1'b0});
		setWord(idDpImmFlags, "stDpImmFlags", {6'b100100, 2'b00, 1'b0, 3'b000, 1'b0, 2'b00,
			1'b0, 1'b0, 2'b01, 1'b0, 3'b000, 1'b0, 5'b00000, 1'b0});
		setWord(idDpShift, "stDpShift", {6'b100100, 2'b00, 1'b1, 3'b000, 1'b0, 2'b00,
			1'b1, 1'b1, 2'b00, 1'b0, 3'b000, 1'b0, 5'b00000, 1'b0});
		setWord(idBranchTarget, "stBranchTarget", {6'b100100, 2'b00, 1'b1, 3'b100, 1'b1,
			2'b11, 1'b0, 1'b0, 2'b11, 1'b1, 3'b100, 1'b0, 5'b10011, 1'b0});
		setWord(idBranchUpdate, "stBranchUpdate", {6'b100000, 2'b10, 1'b0, 3'b011, 1'b1,
			2'b00, 1'b0, 1'b0, 2'b01, 1'b0, 3'b000, 1'b1, 5'b00100, 1'b0});
		setWord(idBranchLink, "stBranchLink", {6'b100000, 2'b11, 1'b0, 3'b100, 1'b1,
			2'b00, 1'b0, 1'b0, 2'b01, 1'b0, 3'b000, 1'b1, 5'b00100, 1'b0});
	endtask

	task automatic addRow(input cuIsaPkg::instrClass cls, input logic link, input logic c,
		input int len, input wordId s0, input wordId s1, input wordId s2);
		rowClass[rowCount] = cls;
		rowLink[rowCount] = link;
		rowCond[rowCount] = c;
		rowLen[rowCount] = len;
		rowSeq[rowCount][0] = s0;
		rowSeq[rowCount][1] = s1;
		rowSeq[rowCount][2] = s2;
		rowCount++;
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic checkWord(input wordId id);
		checkCount++;
		if (ctrlWord !== stateWord[id])
		begin
			errorCount++;
			$display("[FAIL] ctrlWord in %s: expected %h, got %h at %0t ns",
				stateName[id], stateWord[id], ctrlWord, $time);
		end
	endtask

	// one full fetch followed by the execute states of table row r
	task automatic runRow(input int r);
		logic [1:0]             delay;
		int                     waitCycles;
		int                     i;
		logic [`CU_INSTR_W-1:0] instr;
		lfsr = lfsrNext(lfsr);
		delay[0] = lfsr[0];
		lfsr = lfsrNext(lfsr);
		delay[1] = lfsr[0];
		waitCycles = {30'b0, delay};
		instr = 32'h5A5A5A5A;
		instr[`CU_CLASS_HI:`CU_CLASS_LO] = rowClass[r];
		instr[`CU_LINK_BIT] = rowLink[r];
		@(negedge CLK);
		checkWord(idFetchAddr);
		@(negedge CLK);
		checkWord(idFetchReq);
		for (i = 0; i <= waitCycles; i++)
		begin
			@(negedge CLK);
			checkWord(idFetchWait);
			if (i == waitCycles)
			begin
				moc = 1'b1;
				ir = instr;
				cond = rowCond[r];
			end
		end
		@(negedge CLK);
		checkWord(idDecode);
		moc = 1'b0;
		for (i = 0; i < rowLen[r]; i++)
		begin
			@(negedge CLK);
			checkWord(rowSeq[r][i]);
			// once dispatched, the execute states no longer depend on the IR
			ir = ~instr;
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		ir = '0;
		cond = 1'b0;
		moc = 1'b0;
		rowCount = 0;
		checkCount = 0;
		errorCount = 0;
		lfsr = 16'd47;
		loadWords();
		addRow(cuIsaPkg::dpImmediate, 1'b0, 1'b1, 2, idDpImm, idDpImmFlags, idReset);
		addRow(cuIsaPkg::dpShifter, 1'b0, 1'b1, 1, idDpShift, idReset, idReset);
		addRow(cuIsaPkg::branch, 1'b0, 1'b1, 2, idBranchTarget, idBranchUpdate, idReset);
		addRow(cuIsaPkg::branch, 1'b1, 1'b1, 3, idBranchLink, idBranchTarget, idBranchUpdate);
		// failed condition, straight back to fetch
		addRow(cuIsaPkg::dpImmediate, 1'b0, 1'b0, 0, idReset, idReset, idReset);
		addRow(cuIsaPkg::branch, 1'b1, 1'b0, 0, idReset, idReset, idReset);
		// load/store classes run as no-ops
		addRow(cuIsaPkg::lsImmediate, 1'b0, 1'b1, 0, idReset, idReset, idReset);
		addRow(cuIsaPkg::lsRegister, 1'b1, 1'b1, 0, idReset, idReset, idReset);

		repeat (5)
		begin
			@(negedge CLK);
			checkWord(idReset);
		end
		rstN = 1'b1;

		for (int r = 0; r < rowCount; r++)
			runRow(r);

		@(negedge CLK);
		if (ctrlWord !== stateWord[idFetchAddr])
		begin
			errorCount++;
			$display("machine did not return to fetch after the last instruction");
		end

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		#((numRows * 20 + 50) * clkPeriod);
		$display("timeout: the instruction sequence did not complete in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module controlUnit
(
	input  wire logic                   CLK,
	input  wire logic                   rstN,
	input  wire logic [`CU_INSTR_W-1:0] ir,
	input  wire logic                   cond,
	input  wire logic                   moc,
	output logic                        rfLd,
	output logic                        irLd,
	output logic                        marLd,
	output logic                        frLd,
	output logic                        rw,
	output logic                        mov,
	output logic [1:0]                  maSel,
	output logic                        mbSel,
	output logic [`CU_CSEL_W-1:0]       mcSel,
	output logic                        md,
	output logic [1:0]                  mfSel,
	output logic                        mh,
	output logic                        miSel,
	output logic [1:0]                  mjSel,
	output logic                        shiftEn,
	output logic [`CU_SHIFT_W-1:0]      shiftMode,
	output logic                        sBit,
	output logic [`CU_ALUOP_W-1:0]      aluCode,
	output logic                        clr
);

	cuStatePkg::cuState dispatchState;
	cuStatePkg::cuState state;

	instrDecoder u_instrDecoder
	(
		.ir(ir),
		.cond(cond),
		.dispatchState(dispatchState)
	);

	stateSequencer u_stateSequencer
	(
		.CLK(CLK),
		.rstN(rstN),
		.moc(moc),
		.dispatchState(dispatchState),
		.state(state)
	);

	controlRom u_controlRom
	(
		.state(state),
		.rfLd(rfLd),
		.irLd(irLd),
		.marLd(marLd),
		.frLd(frLd),
		.rw(rw),
		.mov(mov),
		.maSel(maSel),
		.mbSel(mbSel),
		.mcSel(mcSel),
		.md(md),
		.mfSel(mfSel),
		.mh(mh),
		.miSel(miSel),
		.mjSel(mjSel),
		.shiftEn(shiftEn),
		.shiftMode(shiftMode),
		.sBit(sBit),
		.aluCode(aluCode),
		.clr(clr)
	);

endmodule

`default_nettype wire

// ==== controlRom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module controlRom
(
	input  wire cuStatePkg::cuState state,
	output logic                    rfLd,
	output logic                    irLd,
	output logic                    marLd,
	output logic                    frLd,
	output logic                    rw,
	output logic                    mov,
	output logic [1:0]              maSel,
	output logic                    mbSel,
	output logic [`CU_CSEL_W-1:0]   mcSel,
	output logic                    md,
	output logic [1:0]              mfSel,
	output logic                    mh,
	output logic                    miSel,
	output logic [1:0]              mjSel,
	output logic                    shiftEn,
	output logic [`CU_SHIFT_W-1:0]  shiftMode,
	output logic                    sBit,
	output logic [`CU_ALUOP_W-1:0]  aluCode,
	output logic                    clr
);

	always_comb
	begin
		rfLd      = 1'b0;
		irLd      = 1'b0;
		marLd     = 1'b0;
		frLd      = 1'b0;
		rw        = 1'b0;
		mov       = 1'b0;
		maSel     = 2'b00;
		mbSel     = 1'b0;
		mcSel     = '0;
		md        = 1'b0;
		mfSel     = 2'b00;
		mh        = 1'b0;
		miSel     = 1'b0;
		mjSel     = 2'b00;
		shiftEn   = 1'b0;
		shiftMode = cuStatePkg::shNone;
		sBit      = 1'b0;
		aluCode   = '0;
		clr       = 1'b0;
		case (state)
			cuStatePkg::stReset:
				clr = 1'b1;
			cuStatePkg::stFetchAddr:
			begin
				// MAR <- PC
				marLd   = 1'b1;
				maSel   = 2'b10;
				md      = 1'b1;
				aluCode = cuStatePkg::opPassB;
			end
			cuStatePkg::stFetchReq:
			begin
				// PC <- PC + 4 while the read starts
				rfLd    = 1'b1;
				rw      = 1'b1;
				mov     = 1'b1;
				maSel   = 2'b10;
				mcSel   = 3'b011;
				md      = 1'b1;
				aluCode = cuStatePkg::opIncr4;
			end
			cuStatePkg::stFetchWait:
			begin
				irLd = 1'b1;
				rw   = 1'b1;
				mov  = 1'b1;
			end
			cuStatePkg::stDpImm:
			begin
				rfLd      = 1'b1;
				mbSel     = 1'b1;
				mcSel     = 3'b100;
				md        = 1'b1;
				shiftEn   = 1'b1;
				shiftMode = cuStatePkg::shImmRotate;
				aluCode   = cuStatePkg::opAddImm;
			end
			cuStatePkg::stDpImmFlags:
			begin
				rfLd  = 1'b1;
				frLd  = 1'b1;
				mjSel = 2'b01;
			end
			cuStatePkg::stDpShift:
			begin
				rfLd  = 1'b1;
				frLd  = 1'b1;
				mbSel = 1'b1;
				mh    = 1'b1;
				miSel = 1'b1;
			end
			cuStatePkg::stBranchTarget:
			begin
				// sign-extended offset shifted left by two
				rfLd      = 1'b1;
				mbSel     = 1'b1;
				frLd      = 1'b1;
				mcSel     = 3'b100;
				md        = 1'b1;
				mfSel     = 2'b11;
				mjSel     = 2'b11;
				shiftEn   = 1'b1;
				shiftMode = cuStatePkg::shBranchOffset;
				aluCode   = cuStatePkg::opAddImm;
			end
			cuStatePkg::stBranchUpdate:
			begin
				rfLd    = 1'b1;
				maSel   = 2'b10;
				mcSel   = 3'b011;
				md      = 1'b1;
				mjSel   = 2'b01;
				sBit    = 1'b1;
				aluCode = cuStatePkg::opTarget;
			end
			cuStatePkg::stBranchLink:
			begin
				// return address goes to the link register
				rfLd    = 1'b1;
				maSel   = 2'b11;
				mcSel   = 3'b100;
				md      = 1'b1;
				mjSel   = 2'b01;
				sBit    = 1'b1;
				aluCode = cuStatePkg::opTarget;
			end
			default:
			begin
				clr = 1'b0;
			end
		endcase
		// rw only ever goes out together with the memory strobe
		assert (!rw || mov);
	end

endmodule

`default_nettype wire

// ==== stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stateSequencer
(
	input  wire logic          CLK,
	input  wire logic          rstN,
	input  wire logic          moc,
	input  wire cuStatePkg::cuState dispatchState,
	output cuStatePkg::cuState state
);

	cuStatePkg::cuState nextState;

	always_comb
	begin
		case (state)
			cuStatePkg::stReset:        nextState = cuStatePkg::stFetchAddr;
			cuStatePkg::stFetchAddr:    nextState = cuStatePkg::stFetchReq;
			cuStatePkg::stFetchReq:     nextState = cuStatePkg::stFetchWait;
			cuStatePkg::stFetchWait:
			begin
				// hold until memory reports completion
				if (moc)
					nextState = cuStatePkg::stDecode;
				else
					nextState = cuStatePkg::stFetchWait;
			end
			cuStatePkg::stDecode:       nextState = dispatchState;
			cuStatePkg::stDpImm:        nextState = cuStatePkg::stDpImmFlags;
			cuStatePkg::stBranchLink:   nextState = cuStatePkg::stBranchTarget;
			cuStatePkg::stBranchTarget: nextState = cuStatePkg::stBranchUpdate;
			default:                    nextState = cuStatePkg::stFetchAddr;
		endcase
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
			state <= cuStatePkg::stReset;
		else
			state <= nextState;
	end

	assert property (@(posedge CLK) disable iff (!rstN)
		state inside {cuStatePkg::stReset, cuStatePkg::stFetchAddr, cuStatePkg::stFetchReq,
			cuStatePkg::stFetchWait, cuStatePkg::stDecode, cuStatePkg::stDpImm,
			cuStatePkg::stDpImmFlags, cuStatePkg::stDpShift, cuStatePkg::stBranchTarget,
			cuStatePkg::stBranchUpdate, cuStatePkg::stBranchLink});

	// no way out of the fetch wait without moc
	assert property (@(posedge CLK) disable iff (!rstN)
		(state == cuStatePkg::stFetchWait && !moc) |=> (state == cuStatePkg::stFetchWait));

endmodule

`default_nettype wire

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module instrDecoder
(
	input  wire logic [`CU_INSTR_W-1:0] ir,
	input  wire logic                   cond,
	output cuStatePkg::cuState          dispatchState
);

	cuIsaPkg::decodedInstr dec;

	assign dec.cls  = cuIsaPkg::instrClass'(ir[`CU_CLASS_HI:`CU_CLASS_LO]);
	assign dec.link = ir[`CU_LINK_BIT];

	always_comb
	begin
		dispatchState = cuStatePkg::stFetchAddr;
		// failed condition skips execution entirely
		if (cond)
		begin
			case (dec.cls)
				cuIsaPkg::dpImmediate:
					dispatchState = cuStatePkg::stDpImm;
				cuIsaPkg::dpShifter:
					dispatchState = cuStatePkg::stDpShift;
				cuIsaPkg::branch:
				begin
					// link saves the return address before the jump
					if (dec.link)
						dispatchState = cuStatePkg::stBranchLink;
					else
						dispatchState = cuStatePkg::stBranchTarget;
				end
				cuIsaPkg::lsImmediate, cuIsaPkg::lsRegister:
					dispatchState = cuStatePkg::stFetchAddr;
				default:
					dispatchState = cuStatePkg::stFetchAddr;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== cuStatePkg.sv ====
`default_nettype none

`include "cu_defs.svh"

package cuStatePkg;

	// state codes keep the microcode numbering
	typedef enum logic [`CU_STATE_W-1:0]
	{
		stReset        = 7'd0,
		stFetchAddr    = 7'd1,
		stFetchReq     = 7'd2,
		stFetchWait    = 7'd3,
		stDecode       = 7'd4,
		stDpImm        = 7'd5,
		stDpImmFlags   = 7'd6,
		stDpShift      = 7'd7,
		stBranchTarget = 7'd8,
		stBranchUpdate = 7'd9,
		stBranchLink   = 7'd10
	} cuState;

	// ALU opcodes driven on aluCode
	typedef enum logic [`CU_ALUOP_W-1:0]
	{
		opPassB  = 5'b10000,
		opIncr4  = 5'b10001,
		opAdd    = 5'b10010,
		opAddImm = 5'b10011,
		opTarget = 5'b00100
	} aluOp;

	// shifter modes, only meaningful with shiftEn
	typedef enum logic [`CU_SHIFT_W-1:0]
	{
		shNone         = 3'b000,
		shImmRotate    = 3'b001,
		shBranchOffset = 3'b100
	} shiftType;

endpackage

`default_nettype wire

// ==== cuIsaPkg.sv ====
`default_nettype none

`include "cu_defs.svh"

package cuIsaPkg;

	// instruction class, taken from ir[27:25]
	typedef enum logic [`CU_CLASS_HI-`CU_CLASS_LO:0]
	{
		dpShifter   = 3'b000,
		dpImmediate = 3'b001,
		lsImmediate = 3'b010,
		lsRegister  = 3'b011,
		branch      = 3'b101
	} instrClass;

	// fields the sequencer cares about
	typedef struct packed
	{
		instrClass cls;
		logic      link;
	} decodedInstr;

endpackage

`default_nettype wire

// ==== cu_defs.svh ====
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

// instruction word as delivered by the IR
`define CU_INSTR_W 32

// sequencer state encoding
`define CU_STATE_W 7

// class field position
`define CU_CLASS_HI 27
`define CU_CLASS_LO 25

// branch with link when set
`define CU_LINK_BIT 20

// control field widths
`define CU_ALUOP_W 5
`define CU_SHIFT_W 3
`define CU_CSEL_W 3

`endif
